//--- bpu_asserts.sv
`timescale 1ns/1ps

module bpu_asserts (
    input logic                        clk,
    input logic                        rst_i,
    input logic                        squash_i,
    input logic [bpu_pkg::VADDR_W-1:0] squash_pc_i,
    input logic                        pred_valid_i,
    input logic                        pred_ready_i,
    input logic [bpu_pkg::VADDR_W-1:0] pred_start_i,
    input logic [bpu_pkg::VADDR_W-1:0] pred_target_i,
    input logic                        pred_taken_i,
    input logic                        pred_redirect_i
);

    int unsigned fail_count = 0;

    redirect_has_valid: assert property (@(posedge clk) disable iff (rst_i)
        pred_redirect_i |-> pred_valid_i)
        else begin
            fail_count++;
            $error("redirect raised without a valid block");
        end

    // a squash offers nothing and the next block starts at the squash address
    squash_reloads_pc: assert property (@(posedge clk) disable iff (rst_i)
        squash_i |-> !pred_valid_i ##1 (squash_i || pred_start_i == $past(squash_pc_i)))
        else begin
            fail_count++;
            $error("squash cycle offered a block or the pc did not reload");
        end

    // a stalled block keeps every field until it is taken or squashed
    stall_keeps_outputs: assert property (@(posedge clk) disable iff (rst_i)
        (pred_valid_i && !pred_ready_i) |=> (squash_i ||
            $stable({pred_valid_i, pred_start_i, pred_target_i, pred_taken_i, pred_redirect_i})))
        else begin
            fail_count++;
            $error("outputs changed while the block was stalled");
        end

    start_aligned: assert property (@(posedge clk) disable iff (rst_i)
        pred_start_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("block start is not 4-byte aligned");
        end

endmodule

bind bpu_stage_ctrl bpu_asserts u_asserts (
    .clk             (clk),
    .rst_i           (rst_i),
    .squash_i        (squash_i),
    .squash_pc_i     (squash_pc_i),
    .pred_valid_i    (pred_valid_o),
    .pred_ready_i    (pred_ready_i),
    .pred_start_i    (pred_start_o),
    .pred_target_i   (pred_target_o),
    .pred_taken_i    (pred_taken_o),
    .pred_redirect_i (pred_redirect_o)
);

//--- bpu_ifs.sv
`timescale 1ns/1ps

// lookup path between the stage controller and the two tables
interface btb_lookup_if;
    import bpu_pkg::*;

    logic [VADDR_W-1:0] lookup_pc;
    logic               lookup_en;
    logic               hold;                                  // tables keep their read data
    btb_entry_t         entry;
    logic               hit;
    ctr_pair_t          ctrs;

    modport producer (
        output lookup_pc, lookup_en, hold,
        input  entry, hit, ctrs
    );

    modport btb_consumer (
        input  lookup_pc, lookup_en, hold,
        output entry, hit
    );

    modport ctr_consumer (
        input  lookup_pc, lookup_en, hold,
        output ctrs
    );

endinterface

// backend training path, taken in every cycle upd_valid is high
interface bpu_update_if;
    import bpu_pkg::*;

    logic               upd_valid;
    logic [VADDR_W-1:0] upd_pc;
    btb_entry_t         upd_entry;
    logic [1:0]         upd_taken;                             // bit 0 slot 0 and bit 1 tail slot
    logic [1:0]         upd_slot_valid;

    modport consumer (
        input upd_valid, upd_pc, upd_entry, upd_taken, upd_slot_valid
    );

endinterface

//--- bpu_pkg.sv
package bpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and fetch block geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int VADDR_W     = 32;
    localparam int INST_OFFSET = 2;                            // every instruction is 4 bytes
    localparam int BLOCK_INSTS = 8;
    localparam int BLOCK_BYTES = BLOCK_INSTS << INST_OFFSET;
    localparam int OFFSET_W    = $clog2(BLOCK_INSTS);

    localparam logic [VADDR_W-1:0] RESET_PC = 32'h0000_1000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // BTB organisation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int BTB_SETS   = 64;
    localparam int BTB_IDX_W  = $clog2(BTB_SETS);
    localparam int BTB_TAG_W  = 10;
    localparam int IDX_LSB    = INST_OFFSET + OFFSET_W;        // index sits right above the block offset
    localparam int TAG_LSB    = IDX_LSB + BTB_IDX_W;
    localparam int BR_TGT_W   = 12;
    localparam int TAIL_TGT_W = 20;

    localparam logic [1:0] CTR_INIT = 2'd1;                    // weakly not taken

    typedef enum logic [1:0] {
        TAR_OK = 2'd0,
        TAR_OV = 2'd1,                                         // high part is fetch high part plus one
        TAR_UN = 2'd2                                          // high part is fetch high part minus one
    } tar_state_e;

    typedef enum logic [1:0] {
        BR_COND = 2'd0,
        BR_JUMP = 2'd1
    } br_kind_e;

    // slot 0 only uses the low BR_TGT_W bits of tgt
    typedef struct packed {
        logic                  en;
        logic [OFFSET_W-1:0]   offset;
        br_kind_e              kind;
        logic [TAIL_TGT_W-1:0] tgt;
        tar_state_e            tar_state;
    } btb_slot_t;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        btb_slot_t            slot0;
        btb_slot_t            tail;
        logic [OFFSET_W-1:0]  fth_offset;                      // last instruction of the block
    } btb_entry_t;

    typedef struct packed {
        logic [1:0] tail;
        logic [1:0] slot0;
    } ctr_pair_t;

    function automatic logic [BTB_IDX_W-1:0] btb_idx(input logic [VADDR_W-1:0] pc);
        return pc[IDX_LSB +: BTB_IDX_W];
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [VADDR_W-1:0] pc);
        return pc[TAG_LSB +: BTB_TAG_W];
    endfunction

endpackage

//--- bpu_stage_ctrl.sv
`timescale 1ns/1ps

module bpu_stage_ctrl (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        squash_i,
    input  logic [bpu_pkg::VADDR_W-1:0] squash_pc_i,
    output logic                        pred_valid_o,
    input  logic                        pred_ready_i,
    output logic [bpu_pkg::VADDR_W-1:0] pred_start_o,
    output logic [bpu_pkg::VADDR_W-1:0] pred_target_o,
    output logic                        pred_taken_o,
    output logic                        pred_redirect_o,
    btb_lookup_if.producer              lookup
);
    import bpu_pkg::*;

    logic [VADDR_W-1:0] pc_q;
    logic [VADDR_W-1:0] s2_start_q;
    logic               s2_valid_q;
    logic               run_q;                                 // low in the first cycle after reset

    logic [VADDR_W-1:0] s1_target;
    logic [VADDR_W-1:0] s2_target;
    logic               s2_taken;
    logic               s2_override;
    logic               fire;

    pred_result_gen u_result_gen (
        .start_i  (s2_start_q),
        .entry_i  (lookup.entry),
        .ctrs_i   (lookup.ctrs),
        .target_o (s2_target),
        .taken_o  (s2_taken)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign s1_target   = pc_q + BLOCK_BYTES;                   // plain fall through
    assign s2_override = s2_valid_q && lookup.hit && (s2_target != s2_start_q + BLOCK_BYTES);

    assign pred_valid_o    = run_q && !squash_i;
    assign pred_start_o    = s2_override ? s2_start_q : pc_q;
    assign pred_target_o   = s2_override ? s2_target : s1_target;
    assign pred_taken_o    = s2_override && s2_taken && !squash_i;
    assign pred_redirect_o = s2_override && !squash_i;

    assign fire = pred_valid_o && pred_ready_i;

    // tables read the block stage 1 offers and freeze while the output stalls
    assign lookup.lookup_pc = pc_q;
    assign lookup.lookup_en = pred_valid_o;
    assign lookup.hold      = !pred_ready_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pc and stage-2 state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q       <= RESET_PC;
            s2_valid_q <= 1'b0;
            run_q      <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (squash_i) begin
                pc_q       <= squash_pc_i;                     // squash wins over everything
                s2_valid_q <= 1'b0;
            end else if (fire && s2_override) begin
                pc_q       <= s2_target;
                s2_valid_q <= 1'b0;                            // the stage-1 block is dropped
            end else if (fire) begin
                pc_q       <= s1_target;
                s2_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !s2_override) begin
            s2_start_q <= pc_q;
        end
    end

endmodule

//--- bpu_top.sv
`timescale 1ns/1ps

module bpu_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        squash_i,
    input  logic [bpu_pkg::VADDR_W-1:0] squash_pc_i,
    input  logic                        upd_valid_i,
    input  logic [bpu_pkg::VADDR_W-1:0] upd_pc_i,
    input  bpu_pkg::btb_entry_t         upd_entry_i,
    input  logic [1:0]                  upd_taken_i,
    input  logic [1:0]                  upd_slot_valid_i,
    output logic                        pred_valid_o,
    input  logic                        pred_ready_i,
    output logic [bpu_pkg::VADDR_W-1:0] pred_start_o,
    output logic [bpu_pkg::VADDR_W-1:0] pred_target_o,
    output logic                        pred_taken_o,
    output logic                        pred_redirect_o
);

    btb_lookup_if lookup_bus ();
    bpu_update_if update_bus ();

    assign update_bus.upd_valid      = upd_valid_i;
    assign update_bus.upd_pc         = upd_pc_i;
    assign update_bus.upd_entry      = upd_entry_i;
    assign update_bus.upd_taken      = upd_taken_i;
    assign update_bus.upd_slot_valid = upd_slot_valid_i;

    btb u_btb (
        .clk    (clk),
        .rst_i  (rst_i),
        .lookup (lookup_bus.btb_consumer),
        .update (update_bus.consumer)
    );

    dir_counter_table u_dir_ctr (
        .clk    (clk),
        .rst_i  (rst_i),
        .lookup (lookup_bus.ctr_consumer),
        .update (update_bus.consumer)
    );

    bpu_stage_ctrl u_stage_ctrl (
        .clk             (clk),
        .rst_i           (rst_i),
        .squash_i        (squash_i),
        .squash_pc_i     (squash_pc_i),
        .pred_valid_o    (pred_valid_o),
        .pred_ready_i    (pred_ready_i),
        .pred_start_o    (pred_start_o),
        .pred_target_o   (pred_target_o),
        .pred_taken_o    (pred_taken_o),
        .pred_redirect_o (pred_redirect_o),
        .lookup          (lookup_bus.producer)
    );

endmodule

//--- btb.sv
`timescale 1ns/1ps

module btb (
    input logic                clk,
    input logic                rst_i,
    btb_lookup_if.btb_consumer lookup,
    bpu_update_if.consumer     update
);
    import bpu_pkg::*;

    btb_entry_t           mem [BTB_SETS];
    logic [BTB_SETS-1:0]  valid_q;

    btb_entry_t           wr_entry;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [BTB_IDX_W-1:0] rd_idx;
    logic                 rd_en;
    logic                 wr_hit_rd;

    btb_entry_t           rd_entry_q;
    logic                 rd_valid_q;
    logic [VADDR_W-1:0]   rd_pc_q;

    assign wr_idx    = btb_idx(update.upd_pc);
    assign rd_idx    = btb_idx(lookup.lookup_pc);
    assign rd_en     = lookup.lookup_en && !lookup.hold;
    assign wr_hit_rd = update.upd_valid && (wr_idx == rd_idx);  // forward the write to the read

    always_comb begin
        wr_entry     = update.upd_entry;
        wr_entry.tag = btb_tag(update.upd_pc);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // valid bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (update.upd_valid) begin
                valid_q[wr_idx] <= wr_entry.valid;
            end
            if (rd_en) begin
                rd_valid_q <= wr_hit_rd ? wr_entry.valid : valid_q[rd_idx];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry storage and read register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (update.upd_valid) begin
            mem[wr_idx] <= wr_entry;
        end
        if (rd_en) begin
            rd_entry_q <= wr_hit_rd ? wr_entry : mem[rd_idx];
            rd_pc_q    <= lookup.lookup_pc;
        end
    end

    always_comb begin
        lookup.entry       = rd_entry_q;
        lookup.entry.valid = rd_valid_q;
    end

    // tag compare uses the address that was registered with the read
    assign lookup.hit = rd_valid_q && (rd_entry_q.tag == btb_tag(rd_pc_q));

endmodule

//--- compile.f
bpu_pkg.sv
bpu_ifs.sv
btb.sv
dir_counter_table.sv
pred_result_gen.sv
bpu_stage_ctrl.sv
bpu_top.sv
bpu_asserts.sv
tb_bpu.sv

//--- dir_counter_table.sv
`timescale 1ns/1ps

module dir_counter_table (
    input logic                clk,
    input logic                rst_i,
    btb_lookup_if.ctr_consumer lookup,
    bpu_update_if.consumer     update
);
    import bpu_pkg::*;

    ctr_pair_t            ctr_q [BTB_SETS];
    ctr_pair_t            trained;
    ctr_pair_t            rd_ctrs_q;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [BTB_IDX_W-1:0] rd_idx;

    // two-bit saturating step
    function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic taken);
        logic [1:0] nxt;
        nxt = ctr;
        if (taken && ctr != 2'd3) begin
            nxt = ctr + 2'd1;
        end else if (!taken && ctr != 2'd0) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

    assign wr_idx = btb_idx(update.upd_pc);
    assign rd_idx = btb_idx(lookup.lookup_pc);

    always_comb begin
        trained = ctr_q[wr_idx];
        if (update.upd_slot_valid[0]) begin
            trained.slot0 = sat_step(trained.slot0, update.upd_taken[0]);
        end
        if (update.upd_slot_valid[1]) begin
            trained.tail = sat_step(trained.tail, update.upd_taken[1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < BTB_SETS; i++) begin
                ctr_q[i] <= '{tail: CTR_INIT, slot0: CTR_INIT};
            end
        end else if (update.upd_valid) begin
            ctr_q[wr_idx] <= trained;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.lookup_en && !lookup.hold) begin
            if (update.upd_valid && wr_idx == rd_idx) begin
                rd_ctrs_q <= trained;                          // same set written this cycle
            end else begin
                rd_ctrs_q <= ctr_q[rd_idx];
            end
        end
    end

    assign lookup.ctrs = rd_ctrs_q;

endmodule

//--- pred_result_gen.sv
`timescale 1ns/1ps

module pred_result_gen (
    input  logic [bpu_pkg::VADDR_W-1:0] start_i,
    input  bpu_pkg::btb_entry_t         entry_i,
    input  bpu_pkg::ctr_pair_t          ctrs_i,
    output logic [bpu_pkg::VADDR_W-1:0] target_o,
    output logic                        taken_o
);
    import bpu_pkg::*;

    localparam int BR_LSB   = BR_TGT_W + INST_OFFSET;
    localparam int TAIL_LSB = TAIL_TGT_W + INST_OFFSET;

    logic               slot0_taken;
    logic               tail_taken;
    logic               slot0_older;
    logic               sel_slot0;

    logic [VADDR_W-1:0] br_low;
    logic [VADDR_W-1:0] tail_low;
    logic [VADDR_W-1:0] br_target;
    logic [VADDR_W-1:0] tail_target;
    logic [VADDR_W-1:0] fth_step;
    logic [VADDR_W-1:0] fth_target;

    // puts the stored low bits under the fetch high bits moved by the target state
    function automatic logic [VADDR_W-1:0] rebuild_target(
        input logic [VADDR_W-1:0] start,
        input logic [VADDR_W-1:0] low,
        input int unsigned        lsb,
        input tar_state_e         state
    );
        logic [VADDR_W-1:0] high;
        high = start >> lsb;
        case (state)
            TAR_OV:  high = high + 1'b1;
            TAR_UN:  high = high - 1'b1;
            default: high = start >> lsb;
        endcase
        return (high << lsb) | low;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // slot direction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // counter bit 1 set means 2 or 3 which is taken
    assign slot0_taken = entry_i.slot0.en && ctrs_i.slot0[1];
    assign tail_taken  = entry_i.tail.en &&
                         (entry_i.tail.kind == BR_JUMP || ctrs_i.tail[1]);

    assign slot0_older = entry_i.slot0.offset <= entry_i.tail.offset;
    assign sel_slot0   = slot0_taken && (!tail_taken || slot0_older);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // target rebuild
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign br_low   = VADDR_W'(entry_i.slot0.tgt[BR_TGT_W-1:0]) << INST_OFFSET;
    assign tail_low = VADDR_W'(entry_i.tail.tgt) << INST_OFFSET;

    assign br_target   = rebuild_target(start_i, br_low, BR_LSB, entry_i.slot0.tar_state);
    assign tail_target = rebuild_target(start_i, tail_low, TAIL_LSB, entry_i.tail.tar_state);

    // fall through ends right after the last instruction of the block
    assign fth_step   = (VADDR_W'(entry_i.fth_offset) + 1'b1) << INST_OFFSET;
    assign fth_target = start_i + fth_step;

    always_comb begin
        if (sel_slot0) begin
            target_o = br_target;
        end else if (tail_taken) begin
            target_o = tail_target;
        end else begin
            target_o = fth_target;
        end
    end

    assign taken_o = slot0_taken || tail_taken;

endmodule

//--- tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu;
    import bpu_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int ROUNDS      = 40;
    localparam int PRED_CYCLES = 60;
    localparam int BLOCK_SHIFT = $clog2(BLOCK_BYTES);

    logic               clk;
    logic               rst_i;
    logic               squash_i;
    logic [VADDR_W-1:0] squash_pc_i;
    logic               upd_valid_i;
    logic [VADDR_W-1:0] upd_pc_i;
    btb_entry_t         upd_entry_i;
    logic [1:0]         upd_taken_i;
    logic [1:0]         upd_slot_valid_i;
    logic               pred_valid_o;
    logic               pred_ready_i;
    logic [VADDR_W-1:0] pred_start_o;
    logic [VADDR_W-1:0] pred_target_o;
    logic               pred_taken_o;
    logic               pred_redirect_o;

    btb_entry_t         model_btb [BTB_SETS];
    ctr_pair_t          model_ctr [BTB_SETS];

    logic [VADDR_W-1:0] exp_pc;                                // where the next plain block starts
    logic               pend_valid;                            // a redirect must come next
    logic [VADDR_W-1:0] pend_start;
    logic [VADDR_W-1:0] pend_target;
    logic               pend_taken;
    logic               stall_prev;
    logic               prv_valid;
    logic [VADDR_W-1:0] prv_start;
    logic [VADDR_W-1:0] prv_target;
    logic               prv_taken;
    logic               prv_redirect;
    int unsigned        redirect_count;

    bpu_top dut_i (
        .clk              (clk),
        .rst_i            (rst_i),
        .squash_i         (squash_i),
        .squash_pc_i      (squash_pc_i),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_entry_i      (upd_entry_i),
        .upd_taken_i      (upd_taken_i),
        .upd_slot_valid_i (upd_slot_valid_i),
        .pred_valid_o     (pred_valid_o),
        .pred_ready_i     (pred_ready_i),
        .pred_start_o     (pred_start_o),
        .pred_target_o    (pred_target_o),
        .pred_taken_o     (pred_taken_o),
        .pred_redirect_o  (pred_redirect_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(ROUNDS * 100 * CLK_PERIOD * 2);
        $display("timeout: the run did not reach its end in time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [BTB_IDX_W-1:0] set_of(input logic [VADDR_W-1:0] pc);
        return BTB_IDX_W'(pc >> BLOCK_SHIFT);
    endfunction

    function automatic logic [BTB_TAG_W-1:0] tag_of(input logic [VADDR_W-1:0] pc);
        return BTB_TAG_W'(pc >> (BLOCK_SHIFT + BTB_IDX_W));
    endfunction

    function automatic logic [1:0] train_ctr(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

    // stored bits form the low part and the fetch region moves up or down by one span
    function automatic logic [VADDR_W-1:0] slot_target(input logic [VADDR_W-1:0] start,
                                                       input logic [TAIL_TGT_W-1:0] bits,
                                                       input int width,
                                                       input tar_state_e state);
        logic [VADDR_W-1:0] span;
        logic [VADDR_W-1:0] upper;
        logic [VADDR_W-1:0] low;
        span  = 32'd1 << (width + INST_OFFSET);
        upper = start & ~(span - 32'd1);
        low   = (VADDR_W'(bits) & ((32'd1 << width) - 32'd1)) << INST_OFFSET;
        if (state == TAR_OV) begin
            upper = upper + span;
        end else if (state == TAR_UN) begin
            upper = upper - span;
        end
        return upper + low;
    endfunction

    task automatic model_update(input logic [VADDR_W-1:0] pc, input btb_entry_t e,
                                input logic [1:0] taken, input logic [1:0] slots);
        logic [BTB_IDX_W-1:0] idx;
        idx             = set_of(pc);
        e.tag           = tag_of(pc);
        model_btb[idx]  = e;
        if (slots[0]) begin
            model_ctr[idx].slot0 = train_ctr(model_ctr[idx].slot0, taken[0]);
        end
        if (slots[1]) begin
            model_ctr[idx].tail = train_ctr(model_ctr[idx].tail, taken[1]);
        end
    endtask

    task automatic model_predict(input logic [VADDR_W-1:0] start, output logic hit,
                                 output logic [VADDR_W-1:0] target, output logic taken);
        btb_entry_t e;
        ctr_pair_t  c;
        logic       t0;
        logic       t1;
        e      = model_btb[set_of(start)];
        c      = model_ctr[set_of(start)];
        hit    = e.valid && (e.tag == tag_of(start));
        t0     = e.slot0.en && (c.slot0 >= 2'd2);
        t1     = e.tail.en && (e.tail.kind == BR_JUMP || c.tail >= 2'd2);
        taken  = t0 || t1;
        if (t0 && (!t1 || e.slot0.offset <= e.tail.offset)) begin
            target = slot_target(start, e.slot0.tgt, BR_TGT_W, e.slot0.tar_state);
        end else if (t1) begin
            target = slot_target(start, e.tail.tgt, TAIL_TGT_W, e.tail.tar_state);
        end else begin
            target = start + ((VADDR_W'(e.fth_offset) + 32'd1) << INST_OFFSET);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [VADDR_W-1:0] got,
                               input logic [VADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            $display("Test FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_cycle();
        logic               hit;
        logic [VADDR_W-1:0] tgt;
        logic               tkn;
        if (stall_prev && !squash_i) begin
            check_value("pred_valid_o", pred_valid_o, prv_valid);
            check_value("pred_start_o", pred_start_o, prv_start);
            check_value("pred_target_o", pred_target_o, prv_target);
            check_value("pred_taken_o", pred_taken_o, prv_taken);
            check_value("pred_redirect_o", pred_redirect_o, prv_redirect);
        end
        if (squash_i) begin
            exp_pc     = squash_pc_i;                          // pc reloads at the next edge
            pend_valid = 1'b0;
        end else if (pred_valid_o && pred_ready_i) begin
            if (pend_valid) begin
                check_value("pred_redirect_o", pred_redirect_o, 1'b1);
                check_value("pred_start_o", pred_start_o, pend_start);
                check_value("pred_target_o", pred_target_o, pend_target);
                check_value("pred_taken_o", pred_taken_o, pend_taken);
                exp_pc         = pend_target;
                pend_valid     = 1'b0;
                redirect_count = redirect_count + 1;
            end else begin
                check_value("pred_redirect_o", pred_redirect_o, 1'b0);
                check_value("pred_start_o", pred_start_o, exp_pc);
                check_value("pred_target_o", pred_target_o, exp_pc + BLOCK_BYTES);
                check_value("pred_taken_o", pred_taken_o, 1'b0);
                model_predict(exp_pc, hit, tgt, tkn);
                if (hit && tgt != exp_pc + BLOCK_BYTES) begin
                    pend_valid  = 1'b1;
                    pend_start  = exp_pc;
                    pend_target = tgt;
                    pend_taken  = tkn;
                end
                exp_pc = exp_pc + BLOCK_BYTES;
            end
        end
        stall_prev   = pred_valid_o && !pred_ready_i;
        prv_valid    = pred_valid_o;
        prv_start    = pred_start_o;
        prv_target   = pred_target_o;
        prv_taken    = pred_taken_o;
        prv_redirect = pred_redirect_o;
    endtask

    always @(negedge clk) begin
        if (rst_i) begin
            exp_pc     = RESET_PC;
            pend_valid = 1'b0;
            stall_prev = 1'b0;
        end else begin
            check_cycle();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic next_cycle();
        @(posedge clk);
        pred_ready_i <= ($urandom_range(0, 9) < 7);            // ready about 70% of cycles
    endtask

    function automatic btb_entry_t random_entry();
        btb_entry_t e;
        e.valid           = ($urandom_range(0, 9) != 0);
        e.tag             = BTB_TAG_W'($urandom);
        e.slot0.en        = ($urandom_range(0, 3) != 0);
        e.slot0.offset    = OFFSET_W'($urandom);
        e.slot0.kind      = BR_COND;
        e.slot0.tgt       = TAIL_TGT_W'($urandom);
        e.slot0.tar_state = tar_state_e'($urandom_range(0, 2));
        e.tail.en         = ($urandom_range(0, 3) != 0);
        e.tail.offset     = OFFSET_W'($urandom);
        e.tail.kind       = $urandom_range(0, 1) ? BR_JUMP : BR_COND;
        e.tail.tgt        = TAIL_TGT_W'($urandom);
        e.tail.tar_state  = tar_state_e'($urandom_range(0, 2));
        e.fth_offset      = OFFSET_W'($urandom);
        return e;
    endfunction

    // updates land on blocks the fetch stream from base walks through
    task automatic train_round();
        logic [VADDR_W-1:0] base;
        logic [VADDR_W-1:0] pc;
        btb_entry_t         e;
        logic [1:0]         taken;
        logic [1:0]         slots;
        int                 n;
        base = $urandom & 32'h00ff_ffe0;
        n    = $urandom_range(8, 16);
        next_cycle();
        squash_i    <= 1'b1;
        squash_pc_i <= base;
        for (int i = 0; i < n; i++) begin
            next_cycle();
            pc    = base + (VADDR_W'($urandom_range(0, 15)) << BLOCK_SHIFT);
            pc    = pc + (VADDR_W'($urandom_range(0, 7)) << INST_OFFSET);
            e     = random_entry();
            taken = 2'($urandom);
            slots = 2'($urandom);
            upd_valid_i      <= 1'b1;
            upd_pc_i         <= pc;
            upd_entry_i      <= e;
            upd_taken_i      <= taken;
            upd_slot_valid_i <= slots;
            model_update(pc, e, taken, slots);
        end
        next_cycle();
        upd_valid_i <= 1'b0;
        next_cycle();
        squash_i <= 1'b0;
    endtask

    initial begin
        void'($urandom(48200));
        rst_i            = 1'b1;
        squash_i         = 1'b0;
        squash_pc_i      = '0;
        upd_valid_i      = 1'b0;
        upd_pc_i         = '0;
        upd_entry_i      = '0;
        upd_taken_i      = '0;
        upd_slot_valid_i = '0;
        pred_ready_i     = 1'b0;
        redirect_count   = 0;
        for (int i = 0; i < BTB_SETS; i++) begin
            model_btb[i] = '0;
            model_ctr[i] = '{tail: 2'd1, slot0: 2'd1};
        end
        repeat (5) next_cycle();
        rst_i <= 1'b0;
        repeat (20) next_cycle();                              // stream from RESET_PC with empty tables
        for (int r = 0; r < ROUNDS; r++) begin
            train_round();
            repeat (PRED_CYCLES) next_cycle();
        end
        next_cycle();
        $display("redirects seen: %0d", redirect_count);
        if (redirect_count == 0) begin
            $display("Test FAILED");
            $fatal(1, "no stage-2 redirect was exercised during the run");
        end else if (dut_i.u_stage_ctrl.u_asserts.fail_count != 0) begin
            $display("Test FAILED");
            $fatal(1, "bound assertions reported errors");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
